//--- project.f
+incdir+.
fme7_pkg.sv
fme7_if.sv
fme7_regs.sv
fme7_irq.sv
fme7_prg_map.sv
fme7_chr_map.sv
fme7_mapper.sv
fme7_sva.sv
tb_fme7.sv

//--- run.sh
#!/bin/sh
# Build the FME-7 testbench with Verilator and run it
# The error limit lets the testbench report the first assertion failure itself
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_fme7 -f project.f -o sim_fme7 \
	&& out=$(./obj_dir/sim_fme7 +verilator+error+limit+1000; true) \
	&& echo "$out" \
	&& echo "$out" | grep -qF "All tests passed!" \
	|| { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

//--- tb_fme7.sv
// FME-7 mapper testbench
`timescale 1ns/1ps
`include "fme7_params.svh"

bind fme7_mapper fme7_sva u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.ce        (ce),
	.prg_ain   (prg_ain),
	.prg_write (prg_write),
	.prg_din   (prg_din),
	.chr_ain   (chr_ain),
	.prg_aout  (prg_aout),
	.prg_allow (prg_allow),
	.chr_aout  (chr_aout),
	.vram_a10  (vram_a10),
	.vram_ce   (vram_ce),
	.irq       (irq)
);

module tb_fme7;

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 16;
	localparam int IRQ_N_MAX     = 67;
	localparam int PRG_CYCLES    = 8 * (8 + 16);
	localparam int CHR_CYCLES    = 4 * (16 + 16);
	localparam int MIRROR_CYCLES = 4 * (2 + 8);
	localparam int IRQ_CYCLES    = 2 * (20 + 2 * IRQ_N_MAX);  // Two countdown runs
	localparam int PLAN_CYCLES   = RESET_CYCLES + PRG_CYCLES + CHR_CYCLES
		+ MIRROR_CYCLES + IRQ_CYCLES + 8;

	logic                    clk;
	logic                    rst_n;
	logic                    ce;
	logic [`FME7_PRG_AW-1:0] prg_ain;
	logic                    prg_write;
	logic [7:0]              prg_din;
	logic [`FME7_CHR_AW-1:0] chr_ain;
	logic [`FME7_OUT_AW-1:0] prg_aout;
	logic                    prg_allow;
	logic [`FME7_OUT_AW-1:0] chr_aout;
	logic                    vram_a10;
	logic                    vram_ce;
	logic                    irq;
	logic [31:0]             lcg_state = 32'd45;

	fme7_mapper u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_ain   (chr_ain),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Low on about one cycle in eight
	function automatic logic random_ce();
		logic [15:0] r;
		r = next_rand();
		return r[2:0] != 3'b000;
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		ce        <= 1'b1;
		prg_write <= 1'b1;
		prg_ain   <= addr;
		prg_din   <= data;
	endtask

	task automatic set_reg(input logic [3:0] cmd, input logic [7:0] data);
		logic [15:0] r;
		r = next_rand();
		cpu_write({3'b100, r[12:0]}, {r[15:12], cmd});  // Upper nibble ignored
		cpu_write({3'b101, r[12:0]}, data);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		ce        <= random_ce();
		prg_write <= 1'b0;
	endtask

	task automatic probe_cycle();
		logic [15:0] r;
		logic [15:0] a;
		logic [2:0]  win;
		r   = next_rand();
		a   = next_rand();
		win = (r[2:0] < 3'd3) ? r[2:0] + 3'd3 : r[2:0];  // $6000-$FFFF only
		@(posedge clk);
		ce        <= random_ce();
		prg_ain   <= {win, a[12:0]};
		prg_write <= r[3] && (win[2:1] != 2'b10);  // Keep off the register port
		chr_ain   <= r[15:2];
	endtask

	task automatic run_irq(input logic [15:0] n);
		set_reg(`FME7_CMD_IRQ_CTRL, 8'h00);
		set_reg(`FME7_CMD_IRQ_LO, n[7:0]);
		set_reg(`FME7_CMD_IRQ_HI, n[15:8]);
		set_reg(`FME7_CMD_IRQ_CTRL, 8'h81);  // Countdown and trigger
		@(negedge clk);
		while (!irq) begin
			idle_cycle();
			@(negedge clk);
		end
		repeat (4) idle_cycle();
		set_reg(`FME7_CMD_IRQ_CTRL, 8'h00);  // Acknowledge
		repeat (4) idle_cycle();
	endtask

	initial begin
		#(2 * PLAN_CYCLES * CLK_PERIOD);
		$display("Timeout: the stimulus did not finish in the expected time");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	always @(negedge clk) begin
		if (u_dut.u_sva.fail_count != 0) begin
			$display("Test failures found");
			$fatal(1, "Stopping at the first failed assertion");
		end
	end

	initial begin
		logic [15:0] r;
		rst_n     <= 1'b0;
		ce        <= 1'b0;
		prg_ain   <= 16'h8123;  // Bank 0 window for the reset check
		prg_write <= 1'b0;
		prg_din   <= 8'h00;
		chr_ain   <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		idle_cycle();

		for (int round = 0; round < 8; round++) begin
			for (int c = 8; c < 12; c++) begin
				r = next_rand();
				set_reg(4'(c), r[7:0]);  // Random RAM enable and select on 8
			end
			repeat (16) probe_cycle();
		end

		for (int round = 0; round < 4; round++) begin
			for (int c = 0; c < 8; c++) begin
				r = next_rand();
				set_reg(4'(c), r[7:0]);
			end
			repeat (16) probe_cycle();
		end

		for (int m = 0; m < 4; m++) begin
			set_reg(`FME7_CMD_MIRROR, 8'(m));
			repeat (8) probe_cycle();
		end

		repeat (2) begin
			r = next_rand();
			run_irq(16'd4 + {10'd0, r[5:0]});
		end

		repeat (4) idle_cycle();
		@(negedge clk);
		#1;
		if (u_dut.u_sva.fail_count != 0) begin
			$display("Test failures found");
			$fatal(1, "Assertion failures detected");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

//--- fme7_sva.sv
// FME-7 mapper assertions
`timescale 1ns/1ps
`include "fme7_params.svh"

module fme7_sva import fme7_pkg::*; (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    ce,
	input logic [`FME7_PRG_AW-1:0] prg_ain,
	input logic                    prg_write,
	input logic [7:0]              prg_din,
	input logic [`FME7_CHR_AW-1:0] chr_ain,
	input logic [`FME7_OUT_AW-1:0] prg_aout,
	input logic                    prg_allow,
	input logic [`FME7_OUT_AW-1:0] chr_aout,
	input logic                    vram_a10,
	input logic                    vram_ce,
	input logic                    irq
);

	int                      fail_count = 0;
	logic                    wr_cmd;
	logic                    wr_param;
	logic [3:0]              sh_cmd;
	chr_banks_t              sh_chr;
	prg_banks_t              sh_prg;
	mirror_t                 sh_mirror;
	logic                    sh_ram_en;
	logic                    sh_ram_sel;
	logic                    sh_countdown;
	logic                    sh_trigger;
	logic [`FME7_IRQ_W-1:0]  sh_counter;
	logic [`FME7_IRQ_W-1:0]  cnt_next;
	logic                    sh_irq;
	logic [`FME7_PRG_BW-1:0] exp_bank;
	logic                    exp_ram_cs;
	logic                    exp_a10;

	assign wr_cmd   = ce && prg_write && prg_ain[15] && (prg_ain[14:13] == 2'b00);
	assign wr_param = ce && prg_write && prg_ain[15] && (prg_ain[14:13] == 2'b01);

	// Decrement first, then byte loads replace their half
	always_comb begin
		cnt_next = sh_counter - {{(`FME7_IRQ_W-1){1'b0}}, sh_countdown};
		if (wr_param && (sh_cmd == `FME7_CMD_IRQ_LO))
			cnt_next[7:0] = prg_din;
		if (wr_param && (sh_cmd == `FME7_CMD_IRQ_HI))
			cnt_next[15:8] = prg_din;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh_cmd       <= '0;
			sh_chr       <= '0;
			sh_prg       <= '0;
			sh_mirror    <= vertical;
			sh_ram_en    <= 1'b0;
			sh_ram_sel   <= 1'b0;
			sh_countdown <= 1'b0;
			sh_trigger   <= 1'b0;
			sh_counter   <= '0;
			sh_irq       <= 1'b0;
		end else begin
			if (wr_cmd)
				sh_cmd <= prg_din[3:0];
			if (wr_param && !sh_cmd[3])
				sh_chr[sh_cmd[2:0]] <= prg_din;
			if (wr_param && (sh_cmd[3:2] == 2'b10))
				sh_prg[sh_cmd[1:0]] <= prg_din[4:0];  // Commands 8-11
			if (wr_param && (sh_cmd == `FME7_CMD_PRG0)) begin
				sh_ram_en  <= prg_din[7];
				sh_ram_sel <= prg_din[6];
			end
			if (wr_param && (sh_cmd == `FME7_CMD_MIRROR))
				sh_mirror <= mirror_t'(prg_din[1:0]);
			if (wr_param && (sh_cmd == `FME7_CMD_IRQ_CTRL)) begin
				sh_countdown <= prg_din[7];
				sh_trigger   <= prg_din[0];
			end
			if (ce) begin
				sh_counter <= cnt_next;
				if (!sh_trigger)
					sh_irq <= 1'b0;
				else if (sh_countdown && (sh_counter == '0))
					sh_irq <= 1'b1;  // Wrap from zero
			end
		end
	end

	always_comb begin
		case (prg_ain[15:13])
			3'd3:    exp_bank = sh_prg[0];
			3'd4:    exp_bank = sh_prg[1];
			3'd5:    exp_bank = sh_prg[2];
			3'd6:    exp_bank = sh_prg[3];
			default: exp_bank = `FME7_LAST_BANK;
		endcase
		case (sh_mirror)
			horizontal: exp_a10 = chr_ain[11];
			single_lo:  exp_a10 = 1'b0;
			single_hi:  exp_a10 = 1'b1;
			default:    exp_a10 = chr_ain[10];
		endcase
	end

	assign exp_ram_cs = !prg_ain[15] && sh_ram_sel;

	a_reset: assert property (@(posedge clk) $rose(rst_n) |-> !irq &&
		(prg_ain[15:13] != 3'b100 || prg_aout == {{(`FME7_OUT_AW-13){1'b0}}, prg_ain[12:0]}))
		else begin
			$error("FAIL %0t: state after reset, prg_aout %h irq %b", $time, prg_aout, irq);
			fail_count++;
		end

	a_prg_window: assert property (@(posedge clk) disable iff (!rst_n)
		prg_ain[15:13] >= 3'd3 |->
		prg_aout == {1'b0, exp_ram_cs, 2'b00, exp_bank, prg_ain[12:0]})
		else begin
			$error("FAIL %0t: prg_aout %h for address %h", $time, prg_aout, prg_ain);
			fail_count++;
		end

	a_prg_allow: assert property (@(posedge clk) disable iff (!rst_n)
		prg_allow == (exp_ram_cs ? sh_ram_en : !prg_write))
		else begin
			$error("FAIL %0t: prg_allow %b for address %h", $time, prg_allow, prg_ain);
			fail_count++;
		end

	a_chr_map: assert property (@(posedge clk) disable iff (!rst_n)
		chr_aout == {4'b1000, sh_chr[chr_ain[12:10]], chr_ain[9:0]} && vram_ce == chr_ain[13])
		else begin
			$error("FAIL %0t: chr_aout %h for address %h", $time, chr_aout, chr_ain);
			fail_count++;
		end

	a_mirror: assert property (@(posedge clk) disable iff (!rst_n) vram_a10 == exp_a10)
		else begin
			$error("FAIL %0t: vram_a10 %b in mode %0d", $time, vram_a10, sh_mirror);
			fail_count++;
		end

	a_irq_count: assert property (@(posedge clk) disable iff (!rst_n) irq == sh_irq)
		else begin
			$error("FAIL %0t: irq %b expected %b", $time, irq, sh_irq);
			fail_count++;
		end

	a_irq_ack: assert property (@(posedge clk) disable iff (!rst_n)
		ce && !sh_trigger |=> !irq)
		else begin
			$error("FAIL %0t: irq still set with trigger clear", $time);
			fail_count++;
		end

endmodule

//--- fme7_mapper.sv
// Sunsoft FME-7 mapper top
`timescale 1ns/1ps
`include "fme7_params.svh"

module fme7_mapper (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ce,         // One clk per CPU cycle

	// CPU side
	input  logic [`FME7_PRG_AW-1:0] prg_ain,
	input  logic                    prg_write,
	input  logic [7:0]              prg_din,
	output logic [`FME7_OUT_AW-1:0] prg_aout,
	output logic                    prg_allow,

	// PPU side
	input  logic [`FME7_CHR_AW-1:0] chr_ain,
	output logic [`FME7_OUT_AW-1:0] chr_aout,
	output logic                    vram_a10,
	output logic                    vram_ce,

	output logic                    irq
);

	bank_cfg_if u_bank_cfg ();
	irq_cfg_if  u_irq_cfg ();

	fme7_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.bank_cfg  (u_bank_cfg.regs),
		.irq_cfg   (u_irq_cfg.regs)
	);

	fme7_irq u_irq (
		.clk   (clk),
		.rst_n (rst_n),
		.ce    (ce),
		.cfg   (u_irq_cfg.irq),
		.irq   (irq)
	);

	fme7_prg_map u_prg_map (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.cfg       (u_bank_cfg.prg),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	fme7_chr_map u_chr_map (
		.chr_ain  (chr_ain),
		.cfg      (u_bank_cfg.chr),
		.chr_aout (chr_aout),
		.vram_a10 (vram_a10),
		.vram_ce  (vram_ce)
	);

endmodule

//--- fme7_chr_map.sv
// FME-7 CHR address translation
`timescale 1ns/1ps
`include "fme7_params.svh"

module fme7_chr_map import fme7_pkg::*; (
	input  logic [`FME7_CHR_AW-1:0] chr_ain,
	bank_cfg_if.chr                 cfg,
	output logic [`FME7_OUT_AW-1:0] chr_aout,
	output logic                    vram_a10,
	output logic                    vram_ce
);

	logic [`FME7_CHR_BW-1:0] bank;

	assign bank = cfg.chr_banks[chr_ain[12:10]];  // 1 kB slot

	// CHR ROM sits above the PRG space in the output map
	assign chr_aout = {4'b1000, bank, chr_ain[9:0]};

	always_comb begin
		case (cfg.mirror)
			vertical:   vram_a10 = chr_ain[10];
			horizontal: vram_a10 = chr_ain[11];
			single_lo:  vram_a10 = 1'b0;
			single_hi:  vram_a10 = 1'b1;
			default:    vram_a10 = chr_ain[10];
		endcase
	end

	// Nametables live in the console's 2 kB VRAM
	assign vram_ce = chr_ain[13];

endmodule

//--- fme7_prg_map.sv
// FME-7 PRG address translation
`timescale 1ns/1ps
`include "fme7_params.svh"

module fme7_prg_map import fme7_pkg::*; (
	input  logic [`FME7_PRG_AW-1:0] prg_ain,
	input  logic                    prg_write,
	bank_cfg_if.prg                 cfg,
	output logic [`FME7_OUT_AW-1:0] prg_aout,
	output logic                    prg_allow
);

	logic [`FME7_PRG_BW-1:0] bank;
	logic                    ram_cs;

	// 8 kB window decode on A15-A13
	always_comb begin
		case (prg_ain[15:13])
			3'b011:  bank = cfg.prg_banks[0];  // $6000
			3'b100:  bank = cfg.prg_banks[1];  // $8000
			3'b101:  bank = cfg.prg_banks[2];  // $A000
			3'b110:  bank = cfg.prg_banks[3];  // $C000
			3'b111:  bank = `FME7_LAST_BANK;   // $E000 is fixed
			default: bank = '0;                // Below $6000 is not ours
		endcase
	end

	assign ram_cs = !prg_ain[15] && cfg.ram_select;

	assign prg_aout  = {1'b0, ram_cs, 2'b00, bank, prg_ain[12:0]};
	assign prg_allow = ram_cs ? cfg.ram_enable : !prg_write;  // ROM is read only

endmodule

//--- fme7_irq.sv
// FME-7 CPU-cycle IRQ counter
`timescale 1ns/1ps
`include "fme7_params.svh"

module fme7_irq (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    ce,
	irq_cfg_if.irq  cfg,
	output logic    irq
);

	logic [`FME7_IRQ_W-1:0] counter;
	logic [`FME7_IRQ_W:0]   dec;          // Top bit flags the wrap from zero
	logic [`FME7_IRQ_W-1:0] counter_nxt;

	assign dec = {1'b0, counter} - {{`FME7_IRQ_W{1'b0}}, cfg.countdown};

	// A byte load wins over the decrement for that byte only
	always_comb begin
		counter_nxt = dec[`FME7_IRQ_W-1:0];
		if (cfg.load_lo)
			counter_nxt[7:0] = cfg.load_data;
		if (cfg.load_hi)
			counter_nxt[`FME7_IRQ_W-1:8] = cfg.load_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			counter <= '0;
			irq     <= 1'b0;
		end else if (ce) begin
			counter <= counter_nxt;
			if (!cfg.trigger)
				irq <= 1'b0;  // Disabling the trigger acknowledges
			else if (dec[`FME7_IRQ_W])
				irq <= 1'b1;  // Sticky until acknowledged
		end
	end

endmodule

//--- fme7_regs.sv
// FME-7 command and parameter registers
`timescale 1ns/1ps
`include "fme7_params.svh"

module fme7_regs import fme7_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ce,
	input  logic [`FME7_PRG_AW-1:0] prg_ain,
	input  logic                    prg_write,
	input  logic [7:0]              prg_din,
	bank_cfg_if.regs                bank_cfg,
	irq_cfg_if.regs                 irq_cfg
);

	logic        cpu_wr;     // Write cycle anywhere in $8000-$FFFF
	logic        cmd_wr;     // $8000-$9FFF
	logic        param_wr;   // $A000-$BFFF
	logic [3:0]  cmd;
	param_byte_u pbyte;

	chr_banks_t  chr_banks;
	prg_banks_t  prg_banks;
	mirror_t     mirror;
	logic        ram_enable;
	logic        ram_select;
	logic        countdown;
	logic        trigger;

	assign cpu_wr   = ce && prg_write && prg_ain[`FME7_PRG_AW-1];
	assign cmd_wr   = cpu_wr && (prg_ain[14:13] == 2'b00);
	assign param_wr = cpu_wr && (prg_ain[14:13] == 2'b01);
	assign pbyte    = prg_din;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd        <= '0;
			chr_banks  <= '0;
			prg_banks  <= '0;
			mirror     <= vertical;
			ram_enable <= 1'b0;
			ram_select <= 1'b0;
			countdown  <= 1'b0;
			trigger    <= 1'b0;
		end else if (cmd_wr) begin
			cmd <= prg_din[3:0];
		end else if (param_wr) begin
			if (!cmd[3]) begin
				chr_banks[cmd[2:0]] <= prg_din;  // Commands 0-7
			end else begin
				case (cmd)
					`FME7_CMD_PRG0: begin
						prg_banks[0] <= pbyte.prg0.bank;
						ram_enable   <= pbyte.prg0.ram_enable;
						ram_select   <= pbyte.prg0.ram_select;
					end
					`FME7_CMD_MIRROR: begin
						mirror <= mirror_t'(prg_din[1:0]);
					end
					`FME7_CMD_IRQ_CTRL: begin
						countdown <= pbyte.irq_ctrl.countdown;
						trigger   <= pbyte.irq_ctrl.trigger;
					end
					default: begin
						// Commands 9 to 11 only; the counter bytes are not held here
						if (cmd[3:2] == 2'b10)
							prg_banks[cmd[1:0]] <= pbyte.prg0.bank;
					end
				endcase
			end
		end
	end

	assign bank_cfg.chr_banks  = chr_banks;
	assign bank_cfg.prg_banks  = prg_banks;
	assign bank_cfg.mirror     = mirror;
	assign bank_cfg.ram_enable = ram_enable;
	assign bank_cfg.ram_select = ram_select;

	assign irq_cfg.countdown = countdown;
	assign irq_cfg.trigger   = trigger;

	// Counter bytes load in the IRQ unit on this same edge
	assign irq_cfg.load_lo   = param_wr && (cmd == `FME7_CMD_IRQ_LO);
	assign irq_cfg.load_hi   = param_wr && (cmd == `FME7_CMD_IRQ_HI);
	assign irq_cfg.load_data = pbyte.raw;

endmodule

//--- fme7_if.sv
// FME-7 configuration interfaces
`timescale 1ns/1ps

// Bank and mirroring state from the register block to the address mappers
interface bank_cfg_if import fme7_pkg::*; ();
	chr_banks_t chr_banks;
	prg_banks_t prg_banks;
	mirror_t    mirror;
	logic       ram_enable;
	logic       ram_select;

	modport regs (
		output chr_banks, prg_banks, mirror, ram_enable, ram_select
	);

	modport prg (
		input prg_banks, ram_enable, ram_select
	);

	modport chr (
		input chr_banks, mirror
	);
endinterface

// Counter control from the register block to the IRQ unit
interface irq_cfg_if ();
	logic       countdown;  // Decrement enable
	logic       trigger;    // IRQ enable
	logic       load_lo;    // One clk wide
	logic       load_hi;    // One clk wide
	logic [7:0] load_data;

	modport regs (
		output countdown, trigger, load_lo, load_hi, load_data
	);

	modport irq (
		input countdown, trigger, load_lo, load_hi, load_data
	);
endinterface

//--- fme7_pkg.sv
// FME-7 mapper types
`include "fme7_params.svh"

package fme7_pkg;

	// Parameter byte as seen by command 8
	typedef struct packed {
		logic                    ram_enable;  // Bit 7
		logic                    ram_select;  // Bit 6 picks RAM over ROM at $6000
		logic                    rsvd;
		logic [`FME7_PRG_BW-1:0] bank;
	} prg0_view_t;

	// Parameter byte as seen by command 13
	typedef struct packed {
		logic       countdown;  // Bit 7
		logic [5:0] rsvd;
		logic       trigger;    // Bit 0
	} irq_ctrl_view_t;

	// One data byte from the CPU with its per-command decodings
	typedef union packed {
		logic [7:0]     raw;
		prg0_view_t     prg0;
		irq_ctrl_view_t irq_ctrl;
	} param_byte_u;

	// CHR banks 0-7 for the 1 kB slots in $0000-$1FFF
	typedef logic [7:0][`FME7_CHR_BW-1:0] chr_banks_t;

	// PRG banks for $6000, $8000, $A000 and $C000
	typedef logic [3:0][`FME7_PRG_BW-1:0] prg_banks_t;

	// Nametable arrangement
	typedef enum logic [1:0] {
		vertical   = 2'd0,
		horizontal = 2'd1,
		single_lo  = 2'd2,
		single_hi  = 2'd3
	} mirror_t;

endpackage

//--- fme7_params.svh
// FME-7 mapper constants
`ifndef FME7_PARAMS_SVH
`define FME7_PARAMS_SVH

// Bus widths
`define FME7_PRG_AW 16  // CPU address
`define FME7_CHR_AW 14  // PPU address
`define FME7_OUT_AW 22  // ROM/RAM address toward the cartridge memories

// Bank register widths
`define FME7_PRG_BW 5   // 8 kB PRG pages
`define FME7_CHR_BW 8   // 1 kB CHR pages

// IRQ down-counter
`define FME7_IRQ_W 16

// Command numbers selected through $8000
`define FME7_CMD_PRG0     4'd8   // PRG bank 0 plus RAM control
`define FME7_CMD_MIRROR   4'd12
`define FME7_CMD_IRQ_CTRL 4'd13
`define FME7_CMD_IRQ_LO   4'd14
`define FME7_CMD_IRQ_HI   4'd15

// Bank seen at $E000 regardless of the registers
`define FME7_LAST_BANK {`FME7_PRG_BW{1'b1}}

`endif
